// ==== rtl/nfcDataOutPkg.sv ====
package nfcDataOutPkg;

    // channel geometry
    localparam int NumberOfWays   = 4;
    localparam int BeatWidth      = 16;
    localparam int ByteCountWidth = 16;
    localparam int BytesPerBeat   = 2;
    localparam int StrobeWidth    = 2;

    // timing in system clock cycles
    localparam int TdqssCycles       = 3;
    localparam int PostambleCycles   = 6;
    localparam int OutputDelayStages = 2; // stages after the DQ launch register

    // wide enough for the longer of the two waits
    localparam int TimerWidth = $clog2(PostambleCycles);

    typedef logic [NumberOfWays-1:0]   wayMaskT;
    typedef logic [ByteCountWidth-1:0] byteCountT;
    typedef logic [BeatWidth-1:0]      beatT;

    typedef struct packed {
        wayMaskT   targetWay;
        byteCountT numOfData;
    } dataOutCmdT;

    typedef struct packed {
        logic [2*NumberOfWays-1:0] chipEnable;  // way mask on both CE banks
        logic                      writeEnable;
        logic                      latchEnable; // shared ALE/CLE drive
    } nandCtrlPinsT;

    typedef struct packed {
        beatT                   dq;
        logic [StrobeWidth-1:0] dqStrobe;
    } dqBusT;

    typedef enum logic [2:0] {
        Idle,
        Latch,
        Setup,     // tDQSS wait
        WaitBeat,
        Arm,       // one cycle with write-ready low before streaming
        Stream,
        Postamble
    } seqStateT;

endpackage

// ==== rtl/dataOutSequencer.sv ====
`timescale 1ns/1ps

module dataOutSequencer (
    input  logic                     iSystemClock,
    input  logic                     iReset,
    input  logic                     iStart,
    input  logic                     iWriteValid,
    input  nfcDataOutPkg::beatT      iWriteData,
    input  logic                     iAllBytesSent,
    output logic                     oReady,
    output logic                     oLastStep,
    output logic                     oWriteReady,
    output logic                     oLatchCommand,
    output logic                     oBeatAccepted,
    output nfcDataOutPkg::seqStateT  oState,
    output nfcDataOutPkg::dqBusT     oLaunch
);

    nfcDataOutPkg::seqStateT state;
    nfcDataOutPkg::seqStateT nextState;

    logic [nfcDataOutPkg::TimerWidth-1:0] timer;
    logic [nfcDataOutPkg::TimerWidth-1:0] timerLimit;
    logic                                 timerDone;

    logic readyQ;
    logic lastStepQ;

    // one timer serves both the tDQSS and the postamble wait
    always_comb begin
        if (state == nfcDataOutPkg::Setup) begin
            timerLimit = nfcDataOutPkg::TimerWidth'(nfcDataOutPkg::TdqssCycles - 1);
        end else begin
            timerLimit = nfcDataOutPkg::TimerWidth'(nfcDataOutPkg::PostambleCycles - 1);
        end
    end

    assign timerDone = (timer == timerLimit);

    always_comb begin
        nextState = state;
        case (state)
            nfcDataOutPkg::Idle: begin
                if (iStart && readyQ) begin
                    nextState = nfcDataOutPkg::Latch;
                end
            end
            nfcDataOutPkg::Latch: begin
                nextState = nfcDataOutPkg::Setup;
            end
            nfcDataOutPkg::Setup: begin
                if (timerDone) begin
                    nextState = nfcDataOutPkg::WaitBeat;
                end
            end
            nfcDataOutPkg::WaitBeat: begin
                if (iWriteValid) begin
                    nextState = nfcDataOutPkg::Arm;
                end
            end
            nfcDataOutPkg::Arm: begin
                nextState = nfcDataOutPkg::Stream;
            end
            nfcDataOutPkg::Stream: begin
                if (iAllBytesSent) begin
                    nextState = nfcDataOutPkg::Postamble;
                end else if (!iWriteValid) begin
                    nextState = nfcDataOutPkg::WaitBeat; // source stalled
                end
            end
            nfcDataOutPkg::Postamble: begin
                if (timerDone) begin
                    nextState = nfcDataOutPkg::Idle;
                end
            end
            default: begin
                nextState = nfcDataOutPkg::Idle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            state <= nfcDataOutPkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            timer <= '0;
        end else if (state != nextState) begin
            timer <= '0;
        end else if (state == nfcDataOutPkg::Setup || state == nfcDataOutPkg::Postamble) begin
            timer <= timer + 1'b1;
        end
    end

    // ready only after a full idle cycle, so the pins have settled to idle
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            readyQ    <= 1'b0;
            lastStepQ <= 1'b0;
        end else begin
            readyQ    <= (state == nfcDataOutPkg::Idle) && (nextState == nfcDataOutPkg::Idle);
            lastStepQ <= (state == nfcDataOutPkg::Postamble) && timerDone;
        end
    end

    // stop pulling beats as soon as the count is complete
    assign oWriteReady   = (state == nfcDataOutPkg::Stream) && !iAllBytesSent;
    assign oBeatAccepted = oWriteReady && iWriteValid;

    // command is captured on the edge into Latch
    assign oLatchCommand = (state == nfcDataOutPkg::Idle) && (nextState == nfcDataOutPkg::Latch);

    always_comb begin
        oLaunch = '0;
        if (oBeatAccepted) begin
            oLaunch.dq       = iWriteData;
            oLaunch.dqStrobe = '1;
        end
    end

    assign oReady    = readyQ;
    assign oLastStep = lastStepQ;
    assign oState    = state;

endmodule

// ==== rtl/transferTracker.sv ====
`timescale 1ns/1ps

module transferTracker (
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  nfcDataOutPkg::dataOutCmdT iCommand,
    input  logic                      iLatchCommand,
    input  logic                      iBeatAccepted,
    output nfcDataOutPkg::wayMaskT    oTargetWay,
    output logic                      oAllBytesSent
);

    nfcDataOutPkg::dataOutCmdT command;
    nfcDataOutPkg::byteCountT  byteCount;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            command <= '0;
        end else if (iLatchCommand) begin
            command <= iCommand;
        end
    end

    // bytes handed to the DQ path so far
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            byteCount <= '0;
        end else if (iLatchCommand) begin
            byteCount <= '0;
        end else if (iBeatAccepted) begin
            byteCount <= byteCount
                + nfcDataOutPkg::ByteCountWidth'(nfcDataOutPkg::BytesPerBeat);
        end
    end

    assign oAllBytesSent = (byteCount == command.numOfData);
    assign oTargetWay    = command.targetWay;

endmodule

// ==== rtl/nandPinDriver.sv ====
`timescale 1ns/1ps

module nandPinDriver (
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  nfcDataOutPkg::seqStateT     iState,
    input  nfcDataOutPkg::wayMaskT      iTargetWay,
    input  nfcDataOutPkg::dqBusT        iLaunch,
    output nfcDataOutPkg::nandCtrlPinsT oCtrlPins,
    output nfcDataOutPkg::dqBusT        oDqBus
);

    nfcDataOutPkg::nandCtrlPinsT ctrlNext;
    nfcDataOutPkg::nandCtrlPinsT ctrlQ;

    nfcDataOutPkg::dqBusT launchQ;
    nfcDataOutPkg::dqBusT delayQ [nfcDataOutPkg::OutputDelayStages];

    always_comb begin
        ctrlNext = '0;

        // WE spans Latch through Postamble
        ctrlNext.writeEnable = (iState != nfcDataOutPkg::Idle);

        if (iState inside {nfcDataOutPkg::Setup, nfcDataOutPkg::WaitBeat,
                           nfcDataOutPkg::Arm, nfcDataOutPkg::Stream,
                           nfcDataOutPkg::Postamble}) begin
            ctrlNext.chipEnable = {iTargetWay, iTargetWay};
        end

        ctrlNext.latchEnable = |iLaunch.dqStrobe; // follows the data launch
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= ctrlNext;
        end
    end

    // launch register then the output delay line
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            launchQ <= '0;
            for (int i = 0; i < nfcDataOutPkg::OutputDelayStages; i++) begin
                delayQ[i] <= '0;
            end
        end else begin
            launchQ   <= iLaunch;
            delayQ[0] <= launchQ;
            for (int i = 1; i < nfcDataOutPkg::OutputDelayStages; i++) begin
                delayQ[i] <= delayQ[i-1];
            end
        end
    end

    assign oCtrlPins = ctrlQ;
    assign oDqBus    = delayQ[nfcDataOutPkg::OutputDelayStages-1];

endmodule

// ==== rtl/nfcDataOutTop.sv ====
`timescale 1ns/1ps

module nfcDataOutTop (
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  logic                        iStart,
    input  nfcDataOutPkg::dataOutCmdT   iCommand,
    output logic                        oReady,
    output logic                        oLastStep,
    input  nfcDataOutPkg::beatT         iWriteData,
    input  logic                        iWriteValid,
    output logic                        oWriteReady,
    output nfcDataOutPkg::nandCtrlPinsT oCtrlPins,
    output nfcDataOutPkg::dqBusT        oDqBus
);

    logic                    latchCommand;
    logic                    beatAccepted;
    logic                    allBytesSent;
    nfcDataOutPkg::wayMaskT  targetWay;
    nfcDataOutPkg::seqStateT seqState;
    nfcDataOutPkg::dqBusT    launch;

    dataOutSequencer dataOutSequencer_i (
        .iSystemClock  (iSystemClock),
        .iReset        (iReset),
        .iStart        (iStart),
        .iWriteValid   (iWriteValid),
        .iWriteData    (iWriteData),
        .iAllBytesSent (allBytesSent),
        .oReady        (oReady),
        .oLastStep     (oLastStep),
        .oWriteReady   (oWriteReady),
        .oLatchCommand (latchCommand),
        .oBeatAccepted (beatAccepted),
        .oState        (seqState),
        .oLaunch       (launch)
    );

    transferTracker transferTracker_i (
        .iSystemClock  (iSystemClock),
        .iReset        (iReset),
        .iCommand      (iCommand),
        .iLatchCommand (latchCommand),
        .iBeatAccepted (beatAccepted),
        .oTargetWay    (targetWay),
        .oAllBytesSent (allBytesSent)
    );

    nandPinDriver nandPinDriver_i (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iState       (seqState),
        .iTargetWay   (targetWay),
        .iLaunch      (launch),
        .oCtrlPins    (oCtrlPins),
        .oDqBus       (oDqBus)
    );

endmodule

// ==== test/dataOutChecker.sv ====
`timescale 1ns/1ps

module dataOutChecker #(
    parameter int NameChars = 12
) (
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  logic                        start,
    input  logic                        ready,
    input  logic                        lastStep,
    input  logic                        writeValid,
    input  logic                        writeReady,
    input  nfcDataOutPkg::nandCtrlPinsT ctrlPins,
    input  nfcDataOutPkg::dqBusT        dqBus,
    input  logic [8*NameChars-1:0]      testName,
    input  int                          testIndex,
    input  nfcDataOutPkg::wayMaskT      expectedWay,
    input  nfcDataOutPkg::byteCountT    expectedByteCount,
    output int                          errorCount,
    output int                          checkCount
);

    localparam int Depth      = nfcDataOutPkg::OutputDelayStages + 1;
    localparam int CtrlSample = 3; // Latch, first Setup cycle, pin register

    logic [8*NameChars-1:0] name;
    int                     index;
    nfcDataOutPkg::wayMaskT way;
    int                     beats;
    logic                   active;
    logic                   readyDue;
    int                     sinceStart;
    int                     acceptCount;
    int                     strobeCount;
    logic [Depth-1:0]       acceptPipe; // bit i set when a beat was taken i+1 samples ago

    task automatic reportMismatch(input string what, input int expected, input int actual);
        errorCount++;
        $display("** Error test %0s: %0s expected 0x%0h, actual 0x%0h",
                 name, what, expected, actual);
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("Error in test %0s: %0s", name, what);
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            reportMismatch(what, expected, actual);
        end
    endtask

    // sampled mid-cycle, away from the rising edge
    always @(negedge iSystemClock) begin : sampleDut
        logic accepted;
        logic strobeDue;
        accepted  = writeValid && writeReady;
        strobeDue = acceptPipe[Depth-1];
        if (iReset) begin
            errorCount = 0;
            checkCount = 0;
            name       = testName;
            index      = 0;
            way        = '0;
            beats      = 0;
            active     = 1'b0;
            readyDue   = 1'b0;
            sinceStart = 0;
            acceptCount = 0;
            strobeCount = 0;
            acceptPipe = '0;
        end else begin
            if (active) begin
                sinceStart++;
            end

            if (dqBus.dqStrobe != '0) begin
                if (!strobeDue) begin
                    reportProblem("strobe on DQ with no beat taken three samples earlier");
                end
                checkValue("dqStrobe", 3, dqBus.dqStrobe);
                checkValue("dq", index * 256 + strobeCount, dqBus.dq);
                strobeCount++;
            end else begin
                if (strobeDue) begin
                    reportProblem("an accepted beat never showed up on DQ");
                end
                checkValue("idle dq", 0, dqBus.dq);
            end

            // latch enable one edge after each launched beat
            checkValue("latchEnable", acceptPipe[0], ctrlPins.latchEnable);

            if (active && sinceStart >= CtrlSample) begin
                checkValue("chipEnable", {way, way}, ctrlPins.chipEnable);
                checkValue("writeEnable", 1, ctrlPins.writeEnable);
            end else if (!active) begin
                checkValue("idle chipEnable", 0, ctrlPins.chipEnable);
                checkValue("idle writeEnable", 0, ctrlPins.writeEnable);
                checkValue("idle writeReady", 0, writeReady);
            end

            if (readyDue) begin
                checkValue("ready after last step", 1, ready);
                readyDue = 1'b0;
            end

            if (accepted) begin
                if (!active) begin
                    reportProblem("beat accepted while no command was running");
                end else if (acceptCount == 0 && sinceStart < nfcDataOutPkg::TdqssCycles) begin
                    reportProblem("first beat accepted before the tDQSS wait was over");
                end
                acceptCount++;
            end

            if (lastStep) begin
                if (!active) begin
                    reportProblem("oLastStep pulsed with no command running");
                end else begin
                    checkValue("beats accepted", beats, acceptCount);
                    checkValue("strobe cycles", beats, strobeCount);
                end
                active   = 1'b0;
                readyDue = 1'b1;
            end

            if (start && ready) begin
                name        = testName;
                index       = testIndex;
                way         = expectedWay;
                beats       = expectedByteCount / nfcDataOutPkg::BytesPerBeat;
                active      = 1'b1;
                sinceStart  = 0;
                acceptCount = 0;
                strobeCount = 0;
            end

            acceptPipe = {acceptPipe[Depth-2:0], accepted};
        end
    end

endmodule

// ==== test/nfcDataOutTb.sv ====
`timescale 1ns/1ps

module nfcDataOutTb;

    localparam int NameChars    = 12;
    localparam int NumTests     = 8;
    localparam int ReadyTimeout = 20;
    localparam int BeatTimeout  = 400;
    localparam int LastTimeout  = 40;

    typedef struct packed {
        logic [8*NameChars-1:0]   name;
        nfcDataOutPkg::wayMaskT   way;
        nfcDataOutPkg::byteCountT byteCount;
        logic                     backPressure;
    } testEntryT;

    logic                        iSystemClock;
    logic                        iReset;
    logic                        start;
    nfcDataOutPkg::dataOutCmdT   command;
    logic                        ready;
    logic                        lastStep;
    nfcDataOutPkg::beatT         writeData;
    logic                        writeValid;
    logic                        writeReady;
    nfcDataOutPkg::nandCtrlPinsT ctrlPins;
    nfcDataOutPkg::dqBusT        dqBus;

    logic [8*NameChars-1:0]   curName;
    int                       curIndex;
    nfcDataOutPkg::wayMaskT   curWay;
    nfcDataOutPkg::byteCountT curByteCount;

    int          errorCount;
    int          checkCount;
    int          timeoutCount;
    logic        aborted;
    int unsigned seedValue;
    testEntryT   testTable [NumTests];

    initial begin
        iSystemClock = 1'b0;
        forever #50 iSystemClock = ~iSystemClock;
    end

    nfcDataOutTop nfcDataOutTop_i (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (start),
        .iCommand     (command),
        .oReady       (ready),
        .oLastStep    (lastStep),
        .iWriteData   (writeData),
        .iWriteValid  (writeValid),
        .oWriteReady  (writeReady),
        .oCtrlPins    (ctrlPins),
        .oDqBus       (dqBus)
    );

    dataOutChecker #(.NameChars(NameChars)) dataOutChecker_i (
        .iSystemClock      (iSystemClock),
        .iReset            (iReset),
        .start             (start),
        .ready             (ready),
        .lastStep          (lastStep),
        .writeValid        (writeValid),
        .writeReady        (writeReady),
        .ctrlPins          (ctrlPins),
        .dqBus             (dqBus),
        .testName          (curName),
        .testIndex         (curIndex),
        .expectedWay       (curWay),
        .expectedByteCount (curByteCount),
        .errorCount        (errorCount),
        .checkCount        (checkCount)
    );

    task automatic loadTestTable();
        testTable[0] = '{name: "one_beat", way: 4'b0001, byteCount: 16'd2, backPressure: 1'b0};
        testTable[1] = '{name: "two_beats", way: 4'b0010, byteCount: 16'd4, backPressure: 1'b0};
        testTable[2] = '{name: "burst_16", way: 4'b0100, byteCount: 16'd32, backPressure: 1'b0};
        testTable[3] = '{name: "all_ways", way: 4'b1111, byteCount: 16'd8, backPressure: 1'b0};
        testTable[4] = '{name: "bp_short", way: 4'b1000, byteCount: 16'd10, backPressure: 1'b1};
        testTable[5] = '{name: "bp_long", way: 4'b0101, byteCount: 16'd48, backPressure: 1'b1};
        testTable[6] = '{name: "bp_mixed", way: 4'b0011, byteCount: 16'd20, backPressure: 1'b1};
        testTable[7] = '{name: "back2back", way: 4'b1010, byteCount: 16'd6, backPressure: 1'b0};
    endtask

    function automatic nfcDataOutPkg::beatT beatValue(input int idx, input int k);
        return nfcDataOutPkg::beatT'(idx * 256 + k);
    endfunction

    // source stalls on about a quarter of the cycles
    function automatic logic sourceWilling(input logic backPressure);
        if (!backPressure) begin
            return 1'b1;
        end
        return ($urandom % 4) != 0;
    endfunction

    task automatic waitForReady();
        int cycles;
        cycles = 0;
        @(negedge iSystemClock);
        while (!ready && cycles < ReadyTimeout) begin
            @(negedge iSystemClock);
            cycles++;
        end
        if (!ready) begin
            $display("Timeout: oReady stayed low, last test %0s", curName);
            timeoutCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic waitForLastStep();
        int cycles;
        cycles = 0;
        @(negedge iSystemClock);
        while (!lastStep && cycles < LastTimeout) begin
            @(negedge iSystemClock);
            cycles++;
        end
        if (!lastStep) begin
            $display("Timeout: oLastStep never pulsed in test %0s", curName);
            timeoutCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic sendBeats(input int idx);
        int   beats;
        int   sent;
        int   cycles;
        logic taken;
        beats      = testTable[idx].byteCount / nfcDataOutPkg::BytesPerBeat;
        sent       = 0;
        cycles     = 0;
        writeData  <= beatValue(idx, 0);
        writeValid <= sourceWilling(testTable[idx].backPressure);
        while (sent < beats && cycles < BeatTimeout) begin
            @(negedge iSystemClock);
            taken = writeValid && writeReady;
            @(posedge iSystemClock);
            if (taken) begin
                sent++;
            end
            writeData  <= beatValue(idx, sent);
            writeValid <= (sent < beats) && sourceWilling(testTable[idx].backPressure);
            cycles++;
        end
        if (sent < beats) begin
            $display("Timeout: only %0d of %0d beats taken in test %0s", sent, beats, curName);
            timeoutCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic runTest(input int idx);
        waitForReady();
        if (!aborted) begin
            @(posedge iSystemClock);
            start        <= 1'b1;
            command      <= '{targetWay: testTable[idx].way, numOfData: testTable[idx].byteCount};
            curName      <= testTable[idx].name;
            curIndex     <= idx;
            curWay       <= testTable[idx].way;
            curByteCount <= testTable[idx].byteCount;
            @(posedge iSystemClock);
            start <= 1'b0;
            sendBeats(idx);
        end
        if (!aborted) begin
            waitForLastStep();
        end
    endtask

    initial begin
        seedValue    = $urandom(81);
        loadTestTable();
        iReset       = 1'b1;
        start        = 1'b0;
        command      = '0;
        writeData    = '0;
        writeValid   = 1'b0;
        curName      = "reset";
        curIndex     = 0;
        curWay       = '0;
        curByteCount = '0;
        timeoutCount = 0;
        aborted      = 1'b0;

        repeat (3) @(posedge iSystemClock);
        iReset <= 1'b0;
        waitForReady(); // idle pins are watched by the checker meanwhile

        for (int i = 0; i < NumTests; i++) begin
            if (!aborted) begin
                runTest(i);
            end
        end

        repeat (2) @(posedge iSystemClock);
        $display("checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0 && checkCount > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/nfcDataOutPkg.sv
rtl/dataOutSequencer.sv
rtl/transferTracker.sv
rtl/nandPinDriver.sv
rtl/nfcDataOutTop.sv
test/dataOutChecker.sv
test/nfcDataOutTb.sv
